//--- logic/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Datapath sizes
`define DATA_W          32
`define SLOT_W          32      // One instruction slot
`define BUNDLE_W        64      // Upper slot [63:32], lower [31:0]
`define REG_CNT         32
`define REG_AW          5       // log2 of REG_CNT

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Credit ports
`define QUEUE_DEPTH     4       // Also upstream credits after reset
`define QPTR_W          2       // log2 of QUEUE_DEPTH
`define RESULT_CREDITS  2
`define CREDIT_W        2       // Holds 0 .. RESULT_CREDITS

`endif

//--- logic/isa_pkg.sv
package isa_pkg;

    // Slot opcode in bits [31:28]
    // Fields rd [27:23], ra [22:18], rb [17:13] and imm [12:0]
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_SRA  = 4'd3,
        OP_SLL  = 4'd4,
        OP_ADDI = 4'd5,
        OP_LI   = 4'd6
    } opcode_t;

    // Operation the exec stage performs on one lane
    typedef enum logic [3:0] {
        E_NOP    = 4'b0000,   // Pass srcb
        E_ADD    = 4'b0001,
        E_SUB    = 4'b0010,
        E_RSHIFT = 4'b0011,   // Arithmetic
        E_LSHIFT = 4'b0100
    } exec_type_t;

endpackage

//--- logic/pipe_pkg.sv
package pipe_pkg;

    // Stage advance condition seen by the control unit
    typedef enum logic [1:0] {
        CTRL_RUN       = 2'd0,
        CTRL_INTERLOCK = 2'd1,   // RAW hazard against exec
        CTRL_STALL     = 2'd2    // No result credit left
    } ctrl_state_t;

endpackage

//--- logic/bundle_queue.sv
`include "core_macros.svh"

module bundle_queue (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 in_valid,
    input  logic [`BUNDLE_W-1:0] in_bundle,
    input  logic                 pop,
    output logic                 q_valid,
    output logic [`BUNDLE_W-1:0] q_bundle,
    output logic                 in_credit
);

    logic [`BUNDLE_W-1:0] mem [`QUEUE_DEPTH];
    logic [`QPTR_W:0]     wr_ptr;   // Extra bit tells full from empty
    logic [`QPTR_W:0]     rd_ptr;
    logic                 do_pop;

    assign q_valid  = (wr_ptr != rd_ptr);
    assign q_bundle = mem[rd_ptr[`QPTR_W-1:0]];
    assign do_pop   = pop & q_valid;

    // Upstream credits guarantee a free entry on every push
    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem[wr_ptr[`QPTR_W-1:0]] <= in_bundle;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            in_credit <= 1'b0;
        end else begin
            if (in_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            in_credit <= do_pop;   // One credit back per freed entry
        end
    end

endmodule

//--- logic/bundle_decode.sv
`include "core_macros.svh"

module bundle_decode (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 load,
    input  logic                 q_valid,
    input  logic [`BUNDLE_W-1:0] q_bundle,
    output logic [`REG_AW-1:0]   rd_addr0,
    output logic [`REG_AW-1:0]   rd_addr1,
    output logic [`REG_AW-1:0]   rd_addr2,
    output logic [`REG_AW-1:0]   rd_addr3,
    input  logic [`DATA_W-1:0]   rd_data0,
    input  logic [`DATA_W-1:0]   rd_data1,
    input  logic [`DATA_W-1:0]   rd_data2,
    input  logic [`DATA_W-1:0]   rd_data3,
    output logic                 dec_valid,
    output logic [1:0]           u_src_used,
    output logic [1:0]           l_src_used,
    output logic [`DATA_W-1:0]   u_srca,
    output logic [`DATA_W-1:0]   u_srcb,
    output isa_pkg::exec_type_t  u_e_type,
    output logic [`REG_AW-1:0]   u_rt,
    output logic                 u_rt_flag,
    output logic [`DATA_W-1:0]   l_srca,
    output logic [`DATA_W-1:0]   l_srcb,
    output isa_pkg::exec_type_t  l_e_type,
    output logic [`REG_AW-1:0]   l_rt,
    output logic                 l_rt_flag
);

    logic [`BUNDLE_W-1:0] dec_bundle;
    logic [`SLOT_W-1:0]   u_slot;
    logic [`SLOT_W-1:0]   l_slot;
    logic                 u_wr;
    logic                 l_wr;

    // Maps one slot to exec type, operands, write flag and used sources
    function automatic void decode_slot(
        input  logic [`SLOT_W-1:0] slot,
        input  logic [`DATA_W-1:0] ra_data,
        input  logic [`DATA_W-1:0] rb_data,
        output isa_pkg::exec_type_t e_type,
        output logic [`DATA_W-1:0] srca,
        output logic [`DATA_W-1:0] srcb,
        output logic               wr,
        output logic [1:0]         used
    );
        logic [`DATA_W-1:0] imm;
        imm    = {{(`DATA_W-13){slot[12]}}, slot[12:0]};
        e_type = isa_pkg::E_NOP;
        srca   = '0;
        srcb   = '0;
        wr     = 1'b1;
        used   = 2'b11;   // bit 0 ra, bit 1 rb
        case (isa_pkg::opcode_t'(slot[31:28]))
            isa_pkg::OP_ADD:  e_type = isa_pkg::E_ADD;
            isa_pkg::OP_SUB:  e_type = isa_pkg::E_SUB;
            isa_pkg::OP_SRA:  e_type = isa_pkg::E_RSHIFT;
            isa_pkg::OP_SLL:  e_type = isa_pkg::E_LSHIFT;
            isa_pkg::OP_ADDI: begin
                e_type = isa_pkg::E_ADD;
                used   = 2'b01;
            end
            isa_pkg::OP_LI:   used = 2'b00;
            default: begin    // NOP and unused codes
                wr   = 1'b0;
                used = 2'b00;
            end
        endcase
        srca = used[0] ? ra_data : '0;
        srcb = used[1] ? rb_data : imm;
    endfunction

    always_ff @(posedge clk) begin
        if (!rstn) begin
            dec_valid <= 1'b0;
        end else if (load) begin
            dec_valid <= q_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            dec_bundle <= q_bundle;
        end
    end

    assign u_slot   = dec_bundle[63:32];
    assign l_slot   = dec_bundle[31:0];
    assign rd_addr0 = u_slot[22:18];
    assign rd_addr1 = u_slot[17:13];
    assign rd_addr2 = l_slot[22:18];
    assign rd_addr3 = l_slot[17:13];
    assign u_rt     = u_slot[27:23];
    assign l_rt     = l_slot[27:23];

    always_comb begin
        decode_slot(u_slot, rd_data0, rd_data1, u_e_type, u_srca, u_srcb, u_wr, u_src_used);
        decode_slot(l_slot, rd_data2, rd_data3, l_e_type, l_srca, l_srcb, l_wr, l_src_used);
    end

    // Writes to r0 are dropped here
    assign u_rt_flag = dec_valid & u_wr & (u_rt != '0);
    assign l_rt_flag = dec_valid & l_wr & (l_rt != '0);

endmodule

//--- logic/reg_file.sv
`include "core_macros.svh"

module reg_file (
    input  logic               clk,
    input  logic               rstn,
    input  logic [`REG_AW-1:0] rd_addr0,
    output logic [`DATA_W-1:0] rd_data0,
    input  logic [`REG_AW-1:0] rd_addr1,
    output logic [`DATA_W-1:0] rd_data1,
    input  logic [`REG_AW-1:0] rd_addr2,
    output logic [`DATA_W-1:0] rd_data2,
    input  logic [`REG_AW-1:0] rd_addr3,
    output logic [`DATA_W-1:0] rd_data3,
    input  logic               wen_u,
    input  logic [`REG_AW-1:0] wa_u,
    input  logic [`DATA_W-1:0] wd_u,
    input  logic               wen_l,
    input  logic [`REG_AW-1:0] wa_l,
    input  logic [`DATA_W-1:0] wd_l
);

    logic [`DATA_W-1:0] regs [`REG_CNT];

    assign rd_data0 = (rd_addr0 == '0) ? '0 : regs[rd_addr0];
    assign rd_data1 = (rd_addr1 == '0) ? '0 : regs[rd_addr1];
    assign rd_data2 = (rd_addr2 == '0) ? '0 : regs[rd_addr2];
    assign rd_data3 = (rd_addr3 == '0) ? '0 : regs[rd_addr3];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < `REG_CNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wen_l) begin
                regs[wa_l] <= wd_l;
            end
            if (wen_u) begin
                regs[wa_u] <= wd_u;   // Last assignment wins on equal address
            end
        end
    end

endmodule

//--- logic/exec.sv
`include "core_macros.svh"

module exec (
    input  logic                clk,
    input  logic                rstn,
    input  logic                interlock,
    input  logic                exec_stall,
    input  logic                in_valid,
    input  logic [`DATA_W-1:0]  u_srca,
    input  logic [`DATA_W-1:0]  u_srcb,
    input  isa_pkg::exec_type_t u_e_type,
    input  logic [`REG_AW-1:0]  u_rt,
    input  logic                u_rt_flag,
    input  logic [`DATA_W-1:0]  l_srca,
    input  logic [`DATA_W-1:0]  l_srcb,
    input  isa_pkg::exec_type_t l_e_type,
    input  logic [`REG_AW-1:0]  l_rt,
    input  logic                l_rt_flag,
    output logic                out_valid,
    output logic [`DATA_W-1:0]  u_tdata,
    output logic [`REG_AW-1:0]  u_rt_out,
    output logic                u_rt_flag_out,
    output logic [`DATA_W-1:0]  l_tdata,
    output logic [`REG_AW-1:0]  l_rt_out,
    output logic                l_rt_flag_out
);

    function automatic logic [`DATA_W-1:0] alu_op(
        input logic [`DATA_W-1:0] srca,
        input logic [`DATA_W-1:0] srcb,
        input isa_pkg::exec_type_t op
    );
        case (op)
            isa_pkg::E_ADD:    alu_op = srca + srcb;
            isa_pkg::E_SUB:    alu_op = srca - srcb;
            isa_pkg::E_RSHIFT: alu_op = $signed(srca) >>> srcb[4:0];
            isa_pkg::E_LSHIFT: alu_op = srca << srcb[4:0];
            default:           alu_op = srcb;   // E_NOP passes srcb
        endcase
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control bits with a bubble under interlock
    always_ff @(posedge clk) begin
        if (!rstn) begin
            out_valid     <= 1'b0;
            u_rt_flag_out <= 1'b0;
            l_rt_flag_out <= 1'b0;
        end else if (!exec_stall) begin
            out_valid     <= in_valid & ~interlock;
            u_rt_flag_out <= u_rt_flag & ~interlock;
            l_rt_flag_out <= l_rt_flag & ~interlock;
        end
    end

    // Lane payload
    always_ff @(posedge clk) begin
        if (!exec_stall && !interlock) begin
            u_tdata  <= alu_op(u_srca, u_srcb, u_e_type);
            u_rt_out <= u_rt;
            l_tdata  <= alu_op(l_srca, l_srcb, l_e_type);
            l_rt_out <= l_rt;
        end
    end

endmodule

//--- logic/pipe_ctrl.sv
`include "core_macros.svh"

module pipe_ctrl (
    input  logic               clk,
    input  logic               rstn,
    input  logic               res_credit,
    input  logic               q_valid,
    input  logic               dec_valid,
    input  logic               exec_valid,
    input  logic [`REG_AW-1:0] u_ra,
    input  logic [`REG_AW-1:0] u_rb,
    input  logic [`REG_AW-1:0] l_ra,
    input  logic [`REG_AW-1:0] l_rb,
    input  logic [1:0]         u_src_used,
    input  logic [1:0]         l_src_used,
    input  logic [`REG_AW-1:0] ex_u_rt,
    input  logic               ex_u_rt_flag,
    input  logic [`REG_AW-1:0] ex_l_rt,
    input  logic               ex_l_rt_flag,
    output logic               dec_load,
    output logic               interlock,
    output logic               exec_stall
);

    pipe_pkg::ctrl_state_t state;
    logic [`CREDIT_W-1:0]  credit_cnt;
    logic                  spend;
    logic                  hazard;

    // True when a used source is still pending in exec
    function automatic logic pending(
        input logic [`REG_AW-1:0] addr,
        input logic               used
    );
        pending = used && (addr != '0) &&
                  ((ex_u_rt_flag && (addr == ex_u_rt)) ||
                   (ex_l_rt_flag && (addr == ex_l_rt)));
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Hazard, stall and stage advance
    assign hazard = dec_valid && exec_valid &&
                    (pending(u_ra, u_src_used[0]) || pending(u_rb, u_src_used[1]) ||
                     pending(l_ra, l_src_used[0]) || pending(l_rb, l_src_used[1]));

    assign exec_stall = exec_valid && (credit_cnt == '0);
    assign interlock  = hazard;

    always_comb begin
        if (exec_stall) begin
            state = pipe_pkg::CTRL_STALL;
        end else if (interlock) begin
            state = pipe_pkg::CTRL_INTERLOCK;
        end else begin
            state = pipe_pkg::CTRL_RUN;
        end
    end

    // Decode refills when empty, or moves on when exec takes its bundle
    assign dec_load = (!dec_valid || (state == pipe_pkg::CTRL_RUN)) && (q_valid || dec_valid);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Result credits
    assign spend = exec_valid && !exec_stall;   // Same cycle as res_valid

    always_ff @(posedge clk) begin
        if (!rstn) begin
            credit_cnt <= `CREDIT_W'(`RESULT_CREDITS);
        end else begin
            case ({res_credit, spend})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;   // None or both
            endcase
        end
    end

endmodule

//--- logic/dual_issue_core.sv
`include "core_macros.svh"

module dual_issue_core (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 in_valid,
    input  logic [`BUNDLE_W-1:0] in_bundle,
    output logic                 in_credit,
    input  logic                 res_credit,
    output logic                 res_valid,
    output logic [`DATA_W-1:0]   res_u_data,
    output logic [`REG_AW-1:0]   res_u_rd,
    output logic                 res_u_wen,
    output logic [`DATA_W-1:0]   res_l_data,
    output logic [`REG_AW-1:0]   res_l_rd,
    output logic                 res_l_wen
);

    logic                 q_valid;
    logic [`BUNDLE_W-1:0] q_bundle;
    logic                 dec_load;
    logic                 dec_valid;
    logic [`REG_AW-1:0]   rd_addr0, rd_addr1, rd_addr2, rd_addr3;
    logic [`DATA_W-1:0]   rd_data0, rd_data1, rd_data2, rd_data3;
    logic [1:0]           u_src_used, l_src_used;
    logic [`DATA_W-1:0]   u_srca, u_srcb, l_srca, l_srcb;
    isa_pkg::exec_type_t  u_e_type, l_e_type;
    logic [`REG_AW-1:0]   u_rt, l_rt;
    logic                 u_rt_flag, l_rt_flag;
    logic                 exec_valid;
    logic                 interlock;
    logic                 exec_stall;
    logic                 wen_u, wen_l;

    // A held result leaves only once a credit is there
    assign res_valid = exec_valid & ~exec_stall;
    assign wen_u     = res_valid & res_u_wen;
    assign wen_l     = res_valid & res_l_wen;

    bundle_queue bundle_queue_inst (
        .clk(clk), .rstn(rstn), .in_valid(in_valid), .in_bundle(in_bundle), .pop(dec_load),
        .q_valid(q_valid), .q_bundle(q_bundle), .in_credit(in_credit));

    bundle_decode bundle_decode_inst (
        .clk(clk), .rstn(rstn), .load(dec_load), .q_valid(q_valid), .q_bundle(q_bundle),
        .rd_addr0(rd_addr0), .rd_addr1(rd_addr1), .rd_addr2(rd_addr2), .rd_addr3(rd_addr3),
        .rd_data0(rd_data0), .rd_data1(rd_data1), .rd_data2(rd_data2), .rd_data3(rd_data3),
        .dec_valid(dec_valid), .u_src_used(u_src_used), .l_src_used(l_src_used),
        .u_srca(u_srca), .u_srcb(u_srcb), .u_e_type(u_e_type), .u_rt(u_rt),
        .u_rt_flag(u_rt_flag), .l_srca(l_srca), .l_srcb(l_srcb), .l_e_type(l_e_type),
        .l_rt(l_rt), .l_rt_flag(l_rt_flag));

    reg_file reg_file_inst (
        .clk(clk), .rstn(rstn),
        .rd_addr0(rd_addr0), .rd_data0(rd_data0), .rd_addr1(rd_addr1), .rd_data1(rd_data1),
        .rd_addr2(rd_addr2), .rd_data2(rd_data2), .rd_addr3(rd_addr3), .rd_data3(rd_data3),
        .wen_u(wen_u), .wa_u(res_u_rd), .wd_u(res_u_data),
        .wen_l(wen_l), .wa_l(res_l_rd), .wd_l(res_l_data));

    exec exec_inst (
        .clk(clk), .rstn(rstn), .interlock(interlock), .exec_stall(exec_stall),
        .in_valid(dec_valid),
        .u_srca(u_srca), .u_srcb(u_srcb), .u_e_type(u_e_type), .u_rt(u_rt),
        .u_rt_flag(u_rt_flag), .l_srca(l_srca), .l_srcb(l_srcb), .l_e_type(l_e_type),
        .l_rt(l_rt), .l_rt_flag(l_rt_flag),
        .out_valid(exec_valid), .u_tdata(res_u_data), .u_rt_out(res_u_rd),
        .u_rt_flag_out(res_u_wen), .l_tdata(res_l_data), .l_rt_out(res_l_rd),
        .l_rt_flag_out(res_l_wen));

    pipe_ctrl pipe_ctrl_inst (
        .clk(clk), .rstn(rstn), .res_credit(res_credit), .q_valid(q_valid),
        .dec_valid(dec_valid), .exec_valid(exec_valid),
        .u_ra(rd_addr0), .u_rb(rd_addr1), .l_ra(rd_addr2), .l_rb(rd_addr3),
        .u_src_used(u_src_used), .l_src_used(l_src_used),
        .ex_u_rt(res_u_rd), .ex_u_rt_flag(res_u_wen),
        .ex_l_rt(res_l_rd), .ex_l_rt_flag(res_l_wen),
        .dec_load(dec_load), .interlock(interlock), .exec_stall(exec_stall));

endmodule

//--- testbench/core_assert.sv
`include "core_macros.svh"

module core_assert (
    input logic                  clk,
    input logic                  rstn,
    input logic                  in_valid,
    input logic                  in_credit,
    input logic                  res_credit,
    input logic                  res_valid,
    input logic [`DATA_W-1:0]    res_u_data,
    input logic [`REG_AW-1:0]    res_u_rd,
    input logic                  res_u_wen,
    input logic [`DATA_W-1:0]    res_l_data,
    input logic [`REG_AW-1:0]    res_l_rd,
    input logic                  res_l_wen,
    input logic                  interlock,
    input logic                  exec_stall,
    input pipe_pkg::ctrl_state_t state
);

    logic fail_seen = 1'b0;   // Polled by the testbench
    int   pushed;
    int   returned;
    int   res_credits;        // Result credits seen at the port

    always @(posedge clk) begin
        if (!rstn) begin
            pushed      <= 0;
            returned    <= 0;
            res_credits <= `RESULT_CREDITS;
        end else begin
            if (in_valid) begin
                pushed <= pushed + 1;
            end
            if (in_credit) begin
                returned <= returned + 1;
            end
            res_credits <= res_credits + int'(res_credit) - int'(res_valid);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_reset_state: assert property (@(posedge clk)
        $rose(rstn) |-> !res_valid && !in_credit && !interlock && !exec_stall
                        && (state == pipe_pkg::CTRL_RUN))
        else begin
            fail_seen = 1'b1;
            $error("ERR %0t: core not idle right after reset", $time);
        end

    a_no_credit: assert property (@(posedge clk) disable iff (!rstn)
        res_valid |-> (res_credits > 0))
        else begin
            fail_seen = 1'b1;
            $error("ERR %0t: result sent with no result credit", $time);
        end

    a_stall_hold: assert property (@(posedge clk) disable iff (!rstn)
        (state == pipe_pkg::CTRL_STALL) |=>
            $stable({res_u_data, res_u_rd, res_u_wen, res_l_data, res_l_rd, res_l_wen}))
        else begin
            fail_seen = 1'b1;
            $error("ERR %0t: result changed during stall", $time);
        end

    // Bubble clears the hazard on the next cycle
    a_interlock_once: assert property (@(posedge clk) disable iff (!rstn)
        (state == pipe_pkg::CTRL_INTERLOCK) |=> (state == pipe_pkg::CTRL_RUN))
        else begin
            fail_seen = 1'b1;
            $error("ERR %0t: interlock lasted more than one cycle", $time);
        end

    a_in_credit: assert property (@(posedge clk) disable iff (!rstn)
        (returned + int'(in_credit)) <= pushed)
        else begin
            fail_seen = 1'b1;
            $error("ERR %0t: more input credits than bundles sent", $time);
        end

endmodule

bind dual_issue_core core_assert core_assert_inst (
    .clk(clk), .rstn(rstn), .in_valid(in_valid), .in_credit(in_credit),
    .res_credit(res_credit), .res_valid(res_valid), .res_u_data(res_u_data),
    .res_u_rd(res_u_rd), .res_u_wen(res_u_wen), .res_l_data(res_l_data),
    .res_l_rd(res_l_rd), .res_l_wen(res_l_wen), .interlock(interlock),
    .exec_stall(exec_stall), .state(pipe_ctrl_inst.state));

//--- testbench/core_tb.sv
`include "core_macros.svh"

module core_tb;

    localparam int NUM_BUNDLES = 200;
    localparam int WAIT_LIMIT  = 20000;   // Cycles per wait loop

    typedef struct packed {
        logic               care;   // Data compared
        logic [`DATA_W-1:0] data;
        logic [`REG_AW-1:0] rd;
        logic               wen;
    } lane_t;

    logic                 clk;
    logic                 rstn;
    logic                 in_valid;
    logic [`BUNDLE_W-1:0] in_bundle;
    logic                 in_credit;
    logic                 res_credit;
    logic                 res_valid;
    logic [`DATA_W-1:0]   res_u_data;
    logic [`REG_AW-1:0]   res_u_rd;
    logic                 res_u_wen;
    logic [`DATA_W-1:0]   res_l_data;
    logic [`REG_AW-1:0]   res_l_rd;
    logic                 res_l_wen;

    integer             seed = 32'h9a48;
    logic [`DATA_W-1:0] model_regs [`REG_CNT];
    lane_t              exp_u_q [$];
    lane_t              exp_l_q [$];
    int                 sent_cnt = 0;
    int                 returned_cnt = 0;
    int                 res_seen = 0;
    int                 credits_given = 0;
    int                 interlock_cycles = 0;
    int                 stall_cycles = 0;

    dual_issue_core dual_issue_core_inst (
        .clk(clk), .rstn(rstn), .in_valid(in_valid), .in_bundle(in_bundle),
        .in_credit(in_credit), .res_credit(res_credit), .res_valid(res_valid),
        .res_u_data(res_u_data), .res_u_rd(res_u_rd), .res_u_wen(res_u_wen),
        .res_l_data(res_l_data), .res_l_rd(res_l_rd), .res_l_wen(res_l_wen));

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_with_fail(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped on error");
    endtask

    // Registers limited to r0..r7 so that hazards show up often
    function automatic logic [31:0] make_slot(input logic [31:0] r);
        logic [3:0] op;
        op = r[31:28] % 4'd7;
        return {op, 2'b00, r[25:23], 2'b00, r[20:18], 2'b00, r[15:13], r[12:0]};
    endfunction

    function automatic lane_t predict_slot(input logic [31:0] slot);
        lane_t              r;
        logic [`DATA_W-1:0] a;
        logic [`DATA_W-1:0] b;
        logic [`DATA_W-1:0] imm;
        a      = model_regs[slot[22:18]];
        b      = model_regs[slot[17:13]];
        imm    = {{(`DATA_W-13){slot[12]}}, slot[12:0]};
        r.care = 1'b1;
        r.rd   = slot[27:23];
        r.wen  = (slot[31:28] != isa_pkg::OP_NOP) && (r.rd != '0);
        case (isa_pkg::opcode_t'(slot[31:28]))
            isa_pkg::OP_ADD:  r.data = a + b;
            isa_pkg::OP_SUB:  r.data = a - b;
            isa_pkg::OP_SRA:  r.data = $signed(a) >>> b[4:0];
            isa_pkg::OP_SLL:  r.data = a << b[4:0];
            isa_pkg::OP_ADDI: r.data = a + imm;
            isa_pkg::OP_LI:   r.data = imm;
            default: begin    // NOP data is don't care
                r.care = 1'b0;
                r.data = '0;
            end
        endcase
        return r;
    endfunction

    function automatic logic lane_ok(input lane_t e, input logic [`DATA_W-1:0] data,
                                     input logic [`REG_AW-1:0] rd, input logic wen);
        return (!e.care || (data == e.data)) && (rd == e.rd) && (wen == e.wen);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Upstream driver and result credit sink
    always @(posedge clk) begin
        logic [`BUNDLE_W-1:0] bundle;
        lane_t                pu;
        lane_t                pl;
        if (!rstn) begin
            in_valid   <= 1'b0;
            res_credit <= 1'b0;
        end else begin
            if ((sent_cnt < NUM_BUNDLES) && (sent_cnt - returned_cnt < `QUEUE_DEPTH)
                    && (($random(seed) & 3) != 0)) begin
                bundle = {make_slot($random(seed)), make_slot($random(seed))};
                pu = predict_slot(bundle[63:32]);   // Both read pre-bundle values
                pl = predict_slot(bundle[31:0]);
                if (pl.wen) begin
                    model_regs[pl.rd] = pl.data;
                end
                if (pu.wen) begin
                    model_regs[pu.rd] = pu.data;     // Upper wins on equal rd
                end
                exp_u_q.push_back(pu);
                exp_l_q.push_back(pl);
                in_valid  <= 1'b1;
                in_bundle <= bundle;
                sent_cnt++;
            end else begin
                in_valid <= 1'b0;
            end
            if ((res_seen > credits_given) && (($random(seed) & 3) == 0)) begin
                res_credit <= 1'b1;
                credits_given++;
            end else begin
                res_credit <= 1'b0;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Monitor sampling mid-cycle
    always @(negedge clk) begin
        lane_t eu;
        lane_t el;
        if (dual_issue_core_inst.core_assert_inst.fail_seen) begin
            stop_with_fail("A bound assertion on the core failed");
        end else if (rstn) begin
            if (in_credit) begin
                returned_cnt++;
            end
            if (dual_issue_core_inst.interlock) begin
                interlock_cycles++;
            end
            if (dual_issue_core_inst.exec_stall) begin
                stall_cycles++;
            end
            if (res_valid && (exp_u_q.size() == 0)) begin
                stop_with_fail("A result came out with no bundle pending");
            end else if (res_valid) begin
                eu = exp_u_q.pop_front();
                el = exp_l_q.pop_front();
                assert (lane_ok(eu, res_u_data, res_u_rd, res_u_wen)
                        && lane_ok(el, res_l_data, res_l_rd, res_l_wen)) res_seen++;
                else stop_with_fail($sformatf(
                    "ERR %0t: result %0d got u %h/%0d/%b l %h/%0d/%b exp u %h/%0d/%b l %h/%0d/%b",
                    $time, res_seen, res_u_data, res_u_rd, res_u_wen, res_l_data, res_l_rd,
                    res_l_wen, eu.data, eu.rd, eu.wen, el.data, el.rd, el.wen));
            end
        end
    end

    initial begin
        int wait_cycles;
        for (int i = 0; i < `REG_CNT; i++) begin
            model_regs[i] = '0;
        end
        rstn       = 1'b0;
        in_valid   = 1'b0;
        in_bundle  = '0;
        res_credit = 1'b0;
        repeat (2) @(posedge clk);
        rstn <= 1'b1;
        wait_cycles = 0;
        while ((res_seen < NUM_BUNDLES) && (wait_cycles < WAIT_LIMIT)) begin
            @(posedge clk);
            wait_cycles++;
        end
        wait_cycles = 0;
        while ((returned_cnt < sent_cnt) && (wait_cycles < WAIT_LIMIT)) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (res_seen < NUM_BUNDLES) begin
            stop_with_fail("Timeout while waiting for all results");
        end else if (returned_cnt < sent_cnt) begin
            stop_with_fail("Timeout while waiting for input credits to return");
        end else if ((interlock_cycles == 0) || (stall_cycles == 0)) begin
            stop_with_fail("Stimulus never reached an interlock or a stall");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

//--- files.f
+incdir+logic
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/bundle_queue.sv
logic/bundle_decode.sv
logic/reg_file.sv
logic/exec.sv
logic/pipe_ctrl.sv
logic/dual_issue_core.sv
testbench/core_assert.sv
testbench/core_tb.sv

//--- Makefile
SRCS = files.f $(wildcard logic/*.sv logic/*.svh testbench/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vcore_tb: $(SRCS)
	verilator --binary --assert --top-module core_tb -f files.f

run: obj_dir/Vcore_tb
	@out="$$(./obj_dir/Vcore_tb +verilator+error+limit+2)"; echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
